// File: source/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    // major opcodes, load and store kept only to be dropped
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_IMM    = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    // encoded as funct3 so decode is a plain cast
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    typedef enum logic [1:0] {XFER_NONE, XFER_BRANCH, XFER_JUMP} xfer_e;

    //////////////////////////////////////////////////
    // stage records

    typedef struct packed {
        alu_op_e  alu_op;
        logic     a_pc;
        logic     b_imm;
        br_cond_e br_cond;
        xfer_e    xfer;
        logic     reg_write;
    } ex_ctrl_t;

    typedef struct packed {
        logic            valid;
        ex_ctrl_t        ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [4:0]      rd;
    } ex_stage_t;

    typedef struct packed {
        logic            valid;
        logic            reg_write;
        logic            jump;
        logic [XLEN-1:0] alu;
        logic [XLEN-1:0] next_pc;
        logic [4:0]      rd;
    } mem_stage_t;

    typedef struct packed {
        logic            valid;
        logic            reg_write;
        logic [4:0]      rd;
        logic [XLEN-1:0] value;
    } wb_stage_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } retire_t;

endpackage

// File: source/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
    input  logic             [31:0] instr,
    input  logic                    valid,
    output rv_pkg::ex_ctrl_t        ctrl,
    output logic             [31:0] imm,
    output logic             [4:0]  rs1,
    output logic             [4:0]  rs2,
    output logic             [4:0]  rd,
    output logic                    rs1_used,
    output logic                    rs2_used,
    output logic                    halt_req
);

    import rv_pkg::*;

    typedef enum logic [2:0] {FMT_NONE, FMT_I, FMT_B, FMT_U, FMT_J} imm_fmt_e;

    opcode_e    opcode;
    logic [2:0] funct3;
    imm_fmt_e   fmt;

    // shared by register and immediate forms, alt picks sub or sra
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // an all-zero word stops the core
    assign halt_req = valid && (instr == 32'd0);

    always_comb begin
        ctrl           = '0;
        ctrl.alu_op    = ALU_ADD;
        ctrl.br_cond   = BR_EQ;
        ctrl.xfer      = XFER_NONE;
        fmt            = FMT_NONE;
        rs1_used       = 1'b0;
        rs2_used       = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op    = alu_from_funct3(funct3, instr[30]);
                ctrl.reg_write = 1'b1;
                rs1_used       = 1'b1;
                rs2_used       = 1'b1;
            end
            OPC_IMM: begin
                // only srai uses bit 30, addi has no subtract
                ctrl.alu_op    = alu_from_funct3(funct3, instr[30] && (funct3 == 3'd5));
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
                rs1_used       = 1'b1;
                fmt            = FMT_I;
            end
            OPC_BRANCH: begin
                // alu forms the target, comparison runs on rs1 and rs2
                ctrl.br_cond = br_cond_e'(funct3);
                ctrl.xfer    = XFER_BRANCH;
                ctrl.a_pc    = 1'b1;
                ctrl.b_imm   = 1'b1;
                rs1_used     = 1'b1;
                rs2_used     = 1'b1;
                fmt          = FMT_B;
            end
            OPC_JAL: begin
                ctrl.xfer      = XFER_JUMP;
                ctrl.a_pc      = 1'b1;
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
                fmt            = FMT_J;
            end
            OPC_JALR: begin
                ctrl.xfer      = XFER_JUMP;
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
                rs1_used       = 1'b1;
                fmt            = FMT_I;
            end
            OPC_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
                fmt            = FMT_U;
            end
            OPC_AUIPC: begin
                ctrl.a_pc      = 1'b1;
                ctrl.b_imm     = 1'b1;
                ctrl.reg_write = 1'b1;
                fmt            = FMT_U;
            end
            // no data memory, these pass through as bubbles
            OPC_LOAD, OPC_STORE: ctrl.reg_write = 1'b0;
            default:             ctrl.reg_write = 1'b0;
        endcase
        // x0 is never written
        if (rd == 5'd0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    always_comb begin
        case (fmt)
            FMT_I:   imm = {{20{instr[31]}}, instr[31:20]};
            FMT_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            FMT_U:   imm = {instr[31:12], 12'd0};
            FMT_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = 32'd0;
        endcase
    end

endmodule

// File: source/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input  logic        CLK,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge CLK) begin
        if (we) begin
            regs[wa] <= wd;
        end
    end

    // asynchronous read, x0 tied to zero
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// File: source/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::ex_stage_t        ex,
    output logic              [31:0] alu_result,
    output logic              [31:0] ex_value,
    output logic                     taken
);

    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] next_pc;
    logic            cond;

    assign op_a    = ex.ctrl.a_pc ? ex.pc : ex.rs1_val;
    assign op_b    = ex.ctrl.b_imm ? ex.imm : ex.rs2_val;
    assign next_pc = ex.pc + XLEN'(4);

    always_comb begin
        case (ex.ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_SLL:    alu_result = op_a << op_b[4:0];
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // branch compare always on the register operands
    always_comb begin
        case (ex.ctrl.br_cond)
            BR_EQ:   cond = ex.rs1_val == ex.rs2_val;
            BR_NE:   cond = ex.rs1_val != ex.rs2_val;
            BR_LT:   cond = $signed(ex.rs1_val) < $signed(ex.rs2_val);
            BR_GE:   cond = $signed(ex.rs1_val) >= $signed(ex.rs2_val);
            BR_LTU:  cond = ex.rs1_val < ex.rs2_val;
            BR_GEU:  cond = ex.rs1_val >= ex.rs2_val;
            default: cond = 1'b0;
        endcase
    end

    assign taken = ex.valid && ((ex.ctrl.xfer == XFER_JUMP) ||
                                (ex.ctrl.xfer == XFER_BRANCH && cond));

    // jumps write the link address
    assign ex_value = (ex.ctrl.xfer == XFER_JUMP) ? next_pc : alu_result;

endmodule

// File: source/rv_forward.sv
`timescale 1ns/10ps

module rv_forward (
    input  logic               [4:0]  rs1,
    input  logic               [4:0]  rs2,
    input  logic                      rs1_used,
    input  logic                      rs2_used,
    input  rv_pkg::ex_stage_t         ex,
    input  logic               [31:0] ex_value,
    input  rv_pkg::mem_stage_t        mem,
    input  rv_pkg::wb_stage_t         wb,
    input  logic               [31:0] rf1,
    input  logic               [31:0] rf2,
    output logic               [31:0] op1,
    output logic               [31:0] op2
);

    import rv_pkg::*;

    logic [XLEN-1:0] mem_value;

    assign mem_value = mem.jump ? mem.next_pc : mem.alu;

    // youngest writer wins, reg_write is already low for x0
    function automatic logic [XLEN-1:0] pick(input logic [4:0] rs,
                                             input logic used,
                                             input logic [XLEN-1:0] rf);
        logic [XLEN-1:0] val;
        val = rf;
        if (used) begin
            if (ex.valid && ex.ctrl.reg_write && ex.rd == rs) begin
                val = ex_value;
            end else if (mem.valid && mem.reg_write && mem.rd == rs) begin
                val = mem_value;
            end else if (wb.valid && wb.reg_write && wb.rd == rs) begin
                val = wb.value;
            end
        end
        return val;
    endfunction

    always_comb begin
        op1 = pick(rs1, rs1_used, rf1);
        op2 = pick(rs2, rs2_used, rf2);
    end

endmodule

// File: source/rv_core.sv
`timescale 1ns/10ps

module rv_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                   CLK,
    input  logic                   RST,
    output logic            [31:0] imem_addr,
    input  logic            [31:0] imem_data,
    output logic                   retire_valid,
    output rv_pkg::retire_t        retire,
    output logic                   done
);

    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] dec_pc;
    logic [31:0]     dec_instr;
    logic            dec_valid;

    ex_ctrl_t        dec_ctrl;
    logic [XLEN-1:0] dec_imm;
    logic [4:0]      dec_rs1;
    logic [4:0]      dec_rs2;
    logic [4:0]      dec_rd;
    logic            rs1_used;
    logic            rs2_used;
    logic            halt_req;

    logic [XLEN-1:0] rf1;
    logic [XLEN-1:0] rf2;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;

    ex_stage_t       ex_q;
    mem_stage_t      mem_q;
    wb_stage_t       wb_q;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] ex_value;
    logic            flush;
    logic            hold;
    logic [1:0]      halt_cnt;

    assign imem_addr = pc;

    rv_decoder u_decoder (
        .instr(dec_instr), .valid(dec_valid), .ctrl(dec_ctrl), .imm(dec_imm),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .rs1_used(rs1_used), .rs2_used(rs2_used), .halt_req(halt_req)
    );

    rv_regfile u_regfile (
        .CLK(CLK), .we(retire_valid), .wa(wb_q.rd), .wd(wb_q.value),
        .ra1(dec_rs1), .ra2(dec_rs2), .rd1(rf1), .rd2(rf2)
    );

    rv_forward u_forward (
        .rs1(dec_rs1), .rs2(dec_rs2), .rs1_used(rs1_used), .rs2_used(rs2_used),
        .ex(ex_q), .ex_value(ex_value), .mem(mem_q), .wb(wb_q),
        .rf1(rf1), .rf2(rf2), .op1(op1), .op2(op2)
    );

    rv_alu u_alu (
        .ex(ex_q), .alu_result(alu_result), .ex_value(ex_value), .taken(flush)
    );

    // an older taken branch cancels a pending halt
    assign hold = halt_req && !flush;
    assign done = (halt_cnt == 2'd3);

    //////////////////////////////////////////////////
    // fetch, decode register and halt counter

    always_ff @(posedge CLK) begin
        if (!hold) begin
            dec_pc    <= pc;
            dec_instr <= imem_data;
        end
        if (RST) begin
            pc        <= RESET_PC;
            dec_valid <= 1'b0;
            halt_cnt  <= 2'd0;
        end else begin
            if (flush) begin
                // jalr needs bit 0 cleared, others already even
                pc        <= {alu_result[XLEN-1:1], 1'b0};
                dec_valid <= 1'b0;
            end else if (!hold) begin
                pc        <= pc + XLEN'(4);
                dec_valid <= 1'b1;
            end
            if (!hold) begin
                halt_cnt <= 2'd0;
            end else if (halt_cnt != 2'd3) begin
                halt_cnt <= halt_cnt + 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // execute, memory and writeback registers

    always_ff @(posedge CLK) begin
        ex_q.ctrl     <= dec_ctrl;
        ex_q.pc       <= dec_pc;
        ex_q.imm      <= dec_imm;
        ex_q.rs1_val  <= op1;
        ex_q.rs2_val  <= op2;
        ex_q.rd       <= dec_rd;

        mem_q.reg_write <= ex_q.ctrl.reg_write;
        mem_q.jump      <= (ex_q.ctrl.xfer == XFER_JUMP);
        mem_q.alu       <= alu_result;
        mem_q.next_pc   <= ex_q.pc + XLEN'(4);
        mem_q.rd        <= ex_q.rd;

        wb_q.reg_write <= mem_q.reg_write;
        wb_q.rd        <= mem_q.rd;
        wb_q.value     <= mem_q.jump ? mem_q.next_pc : mem_q.alu;

        if (RST) begin
            ex_q.valid  <= 1'b0;
            mem_q.valid <= 1'b0;
            wb_q.valid  <= 1'b0;
        end else begin
            // zero word never enters execute
            ex_q.valid  <= dec_valid && !flush && !halt_req;
            mem_q.valid <= ex_q.valid;
            wb_q.valid  <= mem_q.valid;
        end
    end

    assign retire_valid = wb_q.valid && wb_q.reg_write;
    assign retire.rd    = wb_q.rd;
    assign retire.data  = wb_q.value;

endmodule

// File: dv/rv_tb.sv
`timescale 1ns/10ps

module rv_tb;

    import rv_pkg::*;

    logic        CLK;
    logic        RST;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid;
    retire_t     retire;
    logic        done;

    logic [31:0] imem [256];
    logic [31:0] prog [$];
    retire_t     exp_q [$];
    retire_t     got_q [$];
    logic [31:0] rng;
    int          value_errors;
    int          other_errors;
    int          budget;
    int          cycle_count;

    rv_core #(.RESET_PC(32'h0000_0000)) dut (
        .CLK(CLK), .RST(RST), .imem_addr(imem_addr), .imem_data(imem_data),
        .retire_valid(retire_valid), .retire(retire), .done(done)
    );

    // word indexed, answers in the same cycle
    assign imem_data = imem[imem_addr[9:2]];

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // allowance grows as each program is started
    initial begin
        cycle_count = 0;
        while (cycle_count <= budget) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout: the core never reached done after %0d cycles", cycle_count);
        $display("TEST FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // encoders and random values

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // lui plus addi, upper part rounded for the signed low half
    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        prog.push_back(enc_u(7'h37, rd, hi[31:12]));
        prog.push_back(enc_i(7'h13, rd, 3'd0, rd, v[11:0]));
    endtask

    //////////////////////////////////////////////////
    // ISA reference model

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_cond(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic run_model();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] npc;
        logic        wr;
        retire_t     r;
        int          steps;
        exp_q.delete();
        foreach (x[i]) x[i] = 32'd0;
        pc = 32'd0;
        steps = 0;
        w = imem[pc[9:2]];
        while (w != 32'd0 && steps < 2000) begin
            a = x[w[19:15]];
            b = x[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            npc = pc + 32'd4;
            res = 32'd0;
            wr = 1'b1;
            case (w[6:0])
                7'h33: res = ref_alu(w[14:12], w[30], a, b);
                7'h13: res = ref_alu(w[14:12], w[30] && w[14:12] == 3'd5, a, imm_i);
                7'h37: res = {w[31:12], 12'd0};
                7'h17: res = pc + {w[31:12], 12'd0};
                7'h6f: begin
                    res = npc;
                    npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                7'h67: begin
                    res = npc;
                    npc = (a + imm_i) & ~32'd1;
                end
                7'h63: begin
                    wr = 1'b0;
                    if (ref_cond(w[14:12], a, b)) begin
                        npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) begin
                r.rd = w[11:7];
                r.data = res;
                exp_q.push_back(r);
                x[w[11:7]] = res;
            end
            pc = npc;
            w = imem[pc[9:2]];
            steps++;
        end
    endtask

    //////////////////////////////////////////////////
    // run control and checks

    task automatic load_program();
        // spare words write x31 with their own index
        foreach (imem[i]) imem[i] = enc_i(7'h13, 5'd31, 3'd0, 5'd0, 12'(i));
        foreach (prog[i]) imem[i] = prog[i];
    endtask

    task automatic pulse_reset();
        @(negedge CLK);
        RST = 1'b1;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
    endtask

    task automatic step();
        @(negedge CLK);
        if (retire_valid === 1'b1) begin
            got_q.push_back(retire);
        end
    endtask

    task automatic check_retire(input string name, input retire_t exp, input retire_t act);
        if (act !== exp) begin
            $display("error %s: expected x%0d=%08h, actual x%0d=%08h",
                     name, exp.rd, exp.data, act.rd, act.data);
            value_errors++;
        end
    endtask

    task automatic check_done(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s: expected done=%b, actual done=%b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic run_program(input string name);
        int n;
        load_program();
        run_model();
        budget += 10 * prog.size() + 40;
        pulse_reset();
        got_q.delete();
        check_done(name, 1'b0, done);
        while (done !== 1'b1) begin
            step();
        end
        n = got_q.size();
        if (n != exp_q.size()) begin
            $display("%s: %0d results retired before done, %0d were expected",
                     name, n, exp_q.size());
            other_errors++;
        end
        repeat (8) step();
        check_done(name, 1'b1, done);
        if (got_q.size() != n) begin
            $display("%s: the core retired results after done", name);
            other_errors++;
        end
        for (int i = 0; i < n && i < exp_q.size(); i++) begin
            check_retire($sformatf("%s #%0d", name, i), exp_q[i], got_q[i]);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests

    task automatic test_alu();
        logic [31:0] r;
        logic [11:0] imm;
        prog.delete();
        // negative x1 and positive x2 so slt and sltu disagree
        load_const(5'd1, xorshift() | 32'h8000_0000);
        load_const(5'd2, xorshift() & 32'h7fff_ffff);
        for (int f = 0; f < 8; f++) begin
            r = xorshift();
            imm = r[11:0];
            if (f == 1 || f == 5) imm[11:5] = 7'h00;
            prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(f + 3)));
            prog.push_back(enc_i(7'h13, 5'(f + 11), 3'(f), 5'd1, imm));
        end
        prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd19));
        prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd20));
        prog.push_back(enc_i(7'h13, 5'd21, 3'd5, 5'd1, {7'h20, r[16:12]}));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd22));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd23));
        prog.push_back(32'd0);
        run_program("alu");
    endtask

    task automatic test_forward();
        logic [31:0] v;
        logic [2:0]  f3;
        logic [6:0]  f7;
        prog.delete();
        load_const(5'd1, xorshift());
        // x5 feeds the first links of the chain
        load_const(5'd5, xorshift());
        // both sources on the previous result
        prog.push_back(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd2, 3'd0, 5'd3));
        // producer and consumer one to four slots apart
        for (int gap = 0; gap < 4; gap++) begin
            prog.push_back(enc_i(7'h13, 5'd4, 3'd0, 5'd3, 12'(gap * 100 + 7)));
            repeat (gap) prog.push_back(enc_i(7'h13, 5'd0, 3'd0, 5'd0, 12'd0));
            prog.push_back(enc_r(7'h20, 5'd4, 5'd3, 3'd0, 5'd3));
        end
        // random chain, rs1 one back and rs2 two back
        for (int k = 0; k < 12; k++) begin
            v = xorshift();
            f3 = v[2:0];
            f7 = (v[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            prog.push_back(enc_r(f7, 5'((k + 3) % 5 + 1), 5'((k + 4) % 5 + 1), f3,
                                 5'(k % 5 + 1)));
        end
        prog.push_back(32'd0);
        run_program("forward");
    endtask

    task automatic test_branch();
        logic [2:0]  conds [6];
        logic [31:0] a;
        logic [31:0] b;
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        prog.delete();
        foreach (conds[c]) begin
            for (int j = 0; j < 4; j++) begin
                a = xorshift();
                b = (j == 1) ? a : xorshift();
                if (j == 2) begin
                    a[31] = 1'b1;
                    b[31] = 1'b0;
                end else if (j == 3) begin
                    a[31] = 1'b0;
                    b[31] = 1'b1;
                end
                load_const(5'd1, a);
                load_const(5'd2, b);
                prog.push_back(enc_b(conds[c], 5'd1, 5'd2, 13'd12));
                // shadow slots
                prog.push_back(enc_i(7'h13, 5'd10, 3'd0, 5'd0, 12'h111));
                prog.push_back(enc_i(7'h13, 5'd11, 3'd0, 5'd0, 12'h222));
                prog.push_back(enc_i(7'h13, 5'd12, 3'd0, 5'd1, 12'(c * 4 + j)));
            end
        end
        // countdown loop on a backward bne
        prog.push_back(enc_i(7'h13, 5'd13, 3'd0, 5'd0, 12'd3));
        prog.push_back(enc_i(7'h13, 5'd13, 3'd0, 5'd13, 12'hfff));
        prog.push_back(enc_b(3'd1, 5'd13, 5'd0, 13'h1ffc));
        prog.push_back(32'd0);
        run_program("branch");
    endtask

    task automatic test_jump();
        logic [31:0] v;
        int          target;
        prog.delete();
        v = xorshift();
        prog.push_back(enc_j(5'd1, 21'd12));
        prog.push_back(enc_i(7'h13, 5'd10, 3'd0, 5'd0, 12'h0aa));
        prog.push_back(enc_i(7'h13, 5'd11, 3'd0, 5'd0, 12'h0bb));
        prog.push_back(enc_u(7'h17, 5'd3, v[31:12]));
        prog.push_back(enc_u(7'h37, 5'd4, v[19:0]));
        // x0 targets
        prog.push_back(enc_u(7'h37, 5'd0, v[31:12]));
        prog.push_back(enc_i(7'h13, 5'd0, 3'd0, 5'd1, 12'h123));
        prog.push_back(enc_j(5'd0, 21'd8));
        prog.push_back(enc_i(7'h13, 5'd10, 3'd0, 5'd0, 12'h0cc));
        // jalr to an odd address
        target = (prog.size() + 5) * 4;
        load_const(5'd5, 32'(target + 1));
        prog.push_back(enc_i(7'h67, 5'd6, 3'd0, 5'd5, 12'd0));
        prog.push_back(enc_i(7'h13, 5'd10, 3'd0, 5'd0, 12'h0dd));
        prog.push_back(enc_i(7'h13, 5'd11, 3'd0, 5'd0, 12'h0ee));
        prog.push_back(enc_i(7'h13, 5'd7, 3'd0, 5'd6, 12'd1));
        // jalr off the first link, x1 holds 4
        target = (prog.size() + 3) * 4;
        prog.push_back(enc_i(7'h67, 5'd8, 3'd0, 5'd1, 12'(target - 3)));
        prog.push_back(enc_i(7'h13, 5'd10, 3'd0, 5'd0, 12'h0ff));
        prog.push_back(enc_i(7'h13, 5'd11, 3'd0, 5'd0, 12'h011));
        prog.push_back(enc_i(7'h13, 5'd9, 3'd0, 5'd8, 12'd0));
        prog.push_back(32'd0);
        run_program("jump");
    endtask

    task automatic test_halt();
        prog.delete();
        prog.push_back(enc_i(7'h13, 5'd1, 3'd0, 5'd0, 12'h05a));
        prog.push_back(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        // zero word skipped by a taken beq
        prog.push_back(enc_b(3'd0, 5'd0, 5'd0, 13'd12));
        prog.push_back(32'd0);
        prog.push_back(enc_i(7'h13, 5'd10, 3'd0, 5'd0, 12'h0aa));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        prog.push_back(enc_i(7'h13, 5'd4, 3'd0, 5'd3, 12'h7ff));
        prog.push_back(32'd0);
        prog.push_back(enc_i(7'h13, 5'd12, 3'd0, 5'd0, 12'h0ee));
        run_program("halt");
        // reset clears done and starts over at address 0
        run_program("halt restart");
    endtask

    initial begin
        RST = 1'b1;
        rng = 32'h317e_419e;
        value_errors = 0;
        other_errors = 0;
        budget = 20;
        test_alu();
        test_forward();
        test_branch();
        test_jump();
        test_halt();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_forward.sv
source/rv_core.sv
dv/rv_tb.sv

// File: Makefile
all: run

obj_dir/Vrv_tb: compile.f source/*.sv dv/*.sv
	verilator --binary --timing --top-module rv_tb -f compile.f -o Vrv_tb

run: obj_dir/Vrv_tb
	./obj_dir/Vrv_tb | tee sim.log
	grep -q "^TEST PASS$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module rv_tb -f compile.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
